// File: design/fetch_bus_pkg.sv
/*
 * Bus types for the instruction fetch split-transaction bus
 * Address, ASID and beat data widths, cycle-type encoding,
 * transaction id layout, request and response structs
 */
package fetch_bus_pkg;

	// Byte address as seen on the bus
	typedef logic [31:0] address_t;

	// Address-space id, carried with a request but not translated here
	typedef logic [7:0] asid_t;

	// One beat moves a quarter of a cache line
	typedef logic [127:0] data_t;

	// Cycle type of a beat in Wishbone style encoding
	// CLASSIC marks an idle or single cycle, FIXED a beat inside a burst
	// and EOB the last beat of a burst
	typedef enum logic [2:0] {
		CLASSIC = 3'b000,
		FIXED   = 3'b001,
		EOB     = 3'b111
	} cti_t;

	// Every beat carries its own id so responses can return out of order
	typedef struct packed {
		logic [5:0] core;
		logic [5:0] channel;
		logic [3:0] tranid;
	} tid_t;

	// Request side driven by the master
	// There is no handshake, the master holds a beat until rty is low
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [15:0] sel;
		cti_t       cti;
		logic [5:0] blen;
		tid_t       tid;
		address_t   vadr;
		asid_t      asid;
	} bus_req_t;

	// Response side driven by the bus
	// rty is a level that stalls the presented beat
	// ack is a one-cycle pulse returning data for the beat named by tid
	typedef struct packed {
		logic  rty;
		logic  ack;
		tid_t  tid;
		data_t dat;
	} bus_rsp_t;

endpackage

// File: design/icache_pkg.sv
/*
 * Instruction cache geometry
 * Line and index bit positions, set index, beat position and line types
 */
package icache_pkg;

	// A line is 64 bytes, so the line address starts at bit 6
	localparam int LINE_LO_BIT = 6;

	// Four sets give a two bit index in address bits 7:6
	localparam int INDEX_HI_BIT = 7;

	// Set index within the direct-mapped store
	typedef logic [INDEX_HI_BIT-LINE_LO_BIT:0] line_index_t;

	// Position of a 16-byte beat within its line from address bits 5:4
	typedef logic [1:0] quarter_t;

	// A whole line with quarter 0 in the low bits
	typedef logic [511:0] line_data_t;

endpackage

// File: design/lfsr17.sv
/*
 * 17-bit Fibonacci LFSR with clock enable
 * Maximal length with taps 17 and 14, used for random backoff
 */
module lfsr17 (
	input  logic        clk,
	input  logic        rst,
	input  logic        ce,
	output logic [16:0] value
);

	// Any nonzero seed works, the all-zero state is the one lockup state
	localparam logic [16:0] SEED = 17'h0ace1;

	logic feedback;

	// Taps 17 and 14 counted from one map to bits 16 and 13
	assign feedback = value[16] ^ value[13];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			value <= SEED;
		end else if (ce) begin
			value <= {value[15:0], feedback};
		end
	end

endmodule

// File: design/icache_req_generator.sv
/*
 * Miss request generator
 * FSM that issues four read beats per missing line, holds a beat under retry,
 * keeps the tranid to line address table, staggers its start by channel
 * and backs off for a random time after a burst or a snoop abort
 */
module icache_req_generator #(
	parameter logic [5:0]  CORE_NO      = 6'd1,
	parameter logic [5:0]  CHANNEL_ID   = 6'd0,
	parameter int unsigned BACKOFF_WAIT = 6
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            hit,
	input  fetch_bus_pkg::address_t         miss_adr,
	input  fetch_bus_pkg::asid_t            miss_asid,
	input  fetch_bus_pkg::bus_rsp_t         bus_rsp,
	input  logic [2:0]                      rand_bits,
	input  logic                            snoop_v,
	input  fetch_bus_pkg::address_t         snoop_adr,
	input  logic [5:0]                      snoop_cid,
	output fetch_bus_pkg::bus_req_t         bus_req,
	output logic                            lfsr_ce,
	output fetch_bus_pkg::address_t [15:0]  vtags
);
	import fetch_bus_pkg::*;
	import icache_pkg::*;

	// Wide enough to hold BACKOFF_WAIT itself
	localparam int WAIT_W = $clog2(BACKOFF_WAIT + 1) + 1;

	// Each channel waits four cycles per channel number after reset so that
	// several miss units sharing a bus do not all start on the same cycle
	localparam logic [7:0] STARTUP_LAST = {CHANNEL_ID, 2'b00};

	// Beat address step of one quarter line
	localparam address_t BEAT_STEP = 32'd16;

	typedef enum logic [2:0] {
		STARTUP,
		IDLE,
		BEAT0,
		BEAT1,
		BEAT2,
		BEAT3,
		BACKOFF
	} gen_state_t;

	gen_state_t         state;
	logic [7:0]         startup_cnt;
	logic [WAIT_W-1:0]  wait_cnt;
	address_t           line_base;
	logic               snoop_abort;

	// Drop the bus strobes and return the cycle type to idle
	task automatic clear_strobes();
		bus_req.cyc <= 1'b0;
		bus_req.stb <= 1'b0;
		bus_req.sel <= 16'h0000;
		bus_req.cti <= CLASSIC;
	endtask

	// Line-aligned form of the fetch address
	assign line_base = {miss_adr[$bits(address_t)-1:LINE_LO_BIT], {LINE_LO_BIT{1'b0}}};

	// Only the set index is compared, another channel touching the same set
	// may be refilling the very line this unit is after
	assign snoop_abort = snoop_v && (snoop_cid != CHANNEL_ID) && (state != STARTUP) &&
		(snoop_adr[INDEX_HI_BIT:LINE_LO_BIT] == miss_adr[INDEX_HI_BIT:LINE_LO_BIT]);

	// The LFSR stands still during the stagger so every channel starts
	// from the same seed at a different time
	assign lfsr_ce = (state != STARTUP);

	// ==================================================================
	// Request FSM
	// ==================================================================
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= STARTUP;
			startup_cnt <= '0;
			wait_cnt <= '0;
			bus_req <= '0;
		end else begin
			case (state)
			STARTUP: begin
				if (startup_cnt == STARTUP_LAST) begin
					state <= IDLE;
				end else begin
					startup_cnt <= startup_cnt + 8'd1;
				end
			end
			// A miss presents the first beat on the next edge
			IDLE: begin
				if (!hit) begin
					bus_req.cyc <= 1'b1;
					bus_req.stb <= 1'b1;
					bus_req.we <= 1'b0;
					bus_req.sel <= 16'hffff;
					bus_req.cti <= FIXED;
					bus_req.blen <= 6'd4;
					bus_req.tid.core <= CORE_NO;
					bus_req.tid.channel <= CHANNEL_ID;
					bus_req.vadr <= line_base;
					bus_req.asid <= miss_asid;
					state <= BEAT0;
				end
			end
			// Nothing moves while rty is high, the beat stays on the bus as is
			BEAT0, BEAT1, BEAT2: begin
				if (!bus_rsp.rty) begin
					bus_req.vadr <= bus_req.vadr + BEAT_STEP;
					bus_req.tid.tranid <= bus_req.tid.tranid + 4'd1;
					case (state)
					BEAT0: state <= BEAT1;
					BEAT1: state <= BEAT2;
					default: begin
						bus_req.cti <= EOB;
						state <= BEAT3;
					end
					endcase
				end
			end
			// The last beat also moves the tranid on to start the following burst
			BEAT3: begin
				if (!bus_rsp.rty) begin
					clear_strobes();
					bus_req.tid.tranid <= bus_req.tid.tranid + 4'd1;
					wait_cnt <= '0;
					state <= BACKOFF;
				end
			end
			// Wait the fixed minimum, then until the random bits are all ones
			BACKOFF: begin
				if (wait_cnt == WAIT_W'(BACKOFF_WAIT)) begin
					if (rand_bits == 3'b111)
						state <= IDLE;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
			default: state <= STARTUP;
			endcase

			// A foreign snoop on our set overrides whatever the FSM chose
			if (snoop_abort) begin
				clear_strobes();
				wait_cnt <= '0;
				state <= BACKOFF;
				// Skip to the next group of four ids so the fill block can keep
				// deriving the quarter from the two low tranid bits
				if (state inside {BEAT0, BEAT1, BEAT2, BEAT3})
					bus_req.tid.tranid <= {bus_req.tid.tranid[3:2] + 2'd1, 2'b00};
			end
		end
	end

	// ==================================================================
	// Tranid to line address table
	// ==================================================================
	// The entry is written while its beat is on the bus, which is no later
	// than the edge that accepts it, so it is in place before any ack
	always_ff @(posedge clk) begin
		if (bus_req.stb)
			vtags[bus_req.tid.tranid] <=
				{bus_req.vadr[$bits(address_t)-1:LINE_LO_BIT], {LINE_LO_BIT{1'b0}}};
	end

endmodule

// File: design/icache_line_fill.sv
/*
 * Line fill and tag/data store
 * Collects out-of-order beat responses into a fill buffer, writes complete
 * lines into a four-set direct-mapped store, answers hit and fetch data,
 * and invalidates sets named by foreign snoops
 */
module icache_line_fill #(
	parameter logic [5:0] CHANNEL_ID = 6'd0
) (
	input  logic                            clk,
	input  logic                            rst,
	input  fetch_bus_pkg::bus_rsp_t         bus_rsp,
	input  fetch_bus_pkg::address_t [15:0]  vtags,
	input  fetch_bus_pkg::address_t         fetch_adr,
	input  logic                            snoop_v,
	input  fetch_bus_pkg::address_t         snoop_adr,
	input  logic [5:0]                      snoop_cid,
	output logic                            hit,
	output fetch_bus_pkg::data_t            fetch_data
);
	import fetch_bus_pkg::*;
	import icache_pkg::*;

	localparam int TAG_LO_BIT = INDEX_HI_BIT + 1;
	localparam int NUM_LINES = 1 << $bits(line_index_t);

	typedef logic [$bits(address_t)-1:TAG_LO_BIT] tag_t;

	data_t        fill_buf [4];
	logic [3:0]   arrived;
	address_t     fill_adr;
	logic         rsp_mine;
	quarter_t     rsp_quarter;
	logic         fill_done;
	line_index_t  fill_idx;
	line_index_t  fetch_idx;
	line_index_t  snoop_idx;
	quarter_t     fetch_quarter;
	tag_t         tag_mem [NUM_LINES];
	line_data_t   data_mem [NUM_LINES];
	logic [NUM_LINES-1:0] valid;
	line_data_t   fetch_line;

	// Acks for other channels share the response bus and are ignored
	assign rsp_mine = bus_rsp.ack && (bus_rsp.tid.channel == CHANNEL_ID);

	// Bursts always start on a tranid that is a multiple of four,
	// so the two low bits name the quarter
	assign rsp_quarter = bus_rsp.tid.tranid[1:0];

	assign fill_done = &arrived;
	assign fill_idx = fill_adr[INDEX_HI_BIT:LINE_LO_BIT];
	assign snoop_idx = snoop_adr[INDEX_HI_BIT:LINE_LO_BIT];

	// ==================================================================
	// Fill buffer and valid bits
	// ==================================================================
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			arrived <= '0;
			valid <= '0;
		end else begin
			// A new ack landing on the completing edge starts the next line
			arrived <= (fill_done ? 4'b0000 : arrived) |
				(rsp_mine ? (4'b0001 << rsp_quarter) : 4'b0000);
			if (fill_done)
				valid[fill_idx] <= 1'b1;
			// Invalidate after the fill so a snoop on the same edge wins
			if (snoop_v && (snoop_cid != CHANNEL_ID))
				valid[snoop_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_mine) begin
			fill_buf[rsp_quarter] <= bus_rsp.dat;
			fill_adr <= vtags[bus_rsp.tid.tranid];
		end
		if (fill_done) begin
			tag_mem[fill_idx] <= fill_adr[$bits(address_t)-1:TAG_LO_BIT];
			data_mem[fill_idx] <= {fill_buf[3], fill_buf[2], fill_buf[1], fill_buf[0]};
		end
	end

	// ==================================================================
	// Lookup
	// ==================================================================
	assign fetch_idx = fetch_adr[INDEX_HI_BIT:LINE_LO_BIT];
	assign fetch_quarter = fetch_adr[LINE_LO_BIT-1 -: $bits(quarter_t)];

	// Tags of never-filled sets are unknown but masked by the valid bit
	assign hit = valid[fetch_idx] &&
		(tag_mem[fetch_idx] == fetch_adr[$bits(address_t)-1:TAG_LO_BIT]);

	assign fetch_line = data_mem[fetch_idx];
	assign fetch_data = fetch_line[fetch_quarter * $bits(data_t) +: $bits(data_t)];

endmodule

// File: design/icache_miss_unit.sv
/*
 * Instruction cache miss unit
 * Connects the request generator, the backoff LFSR and the fill store
 */
module icache_miss_unit #(
	parameter logic [5:0]  CORE_NO      = 6'd1,
	parameter logic [5:0]  CHANNEL_ID   = 6'd0,
	parameter int unsigned BACKOFF_WAIT = 6
) (
	input  logic                     clk,
	input  logic                     rst,
	input  fetch_bus_pkg::address_t  fetch_adr,
	input  fetch_bus_pkg::asid_t     fetch_asid,
	input  fetch_bus_pkg::bus_rsp_t  bus_rsp,
	input  logic                     snoop_v,
	input  fetch_bus_pkg::address_t  snoop_adr,
	input  logic [5:0]               snoop_cid,
	output fetch_bus_pkg::bus_req_t  bus_req,
	output logic                     fetch_hit,
	output fetch_bus_pkg::data_t     fetch_data
);
	import fetch_bus_pkg::*;

	// Tranid to line address table owned by the generator
	address_t [15:0] vtags;
	logic            lfsr_ce;
	logic [16:0]     lfsr_value;

	// Requests go out for the current fetch address whenever it misses
	icache_req_generator #(
		.CORE_NO      (CORE_NO),
		.CHANNEL_ID   (CHANNEL_ID),
		.BACKOFF_WAIT (BACKOFF_WAIT)
	) icache_req_generator_inst (
		.clk       (clk),
		.rst       (rst),
		.hit       (fetch_hit),
		.miss_adr  (fetch_adr),
		.miss_asid (fetch_asid),
		.bus_rsp   (bus_rsp),
		.rand_bits (lfsr_value[2:0]),
		.snoop_v   (snoop_v),
		.snoop_adr (snoop_adr),
		.snoop_cid (snoop_cid),
		.bus_req   (bus_req),
		.lfsr_ce   (lfsr_ce),
		.vtags     (vtags)
	);

	lfsr17 lfsr17_inst (
		.clk   (clk),
		.rst   (rst),
		.ce    (lfsr_ce),
		.value (lfsr_value)
	);

	icache_line_fill #(
		.CHANNEL_ID (CHANNEL_ID)
	) icache_line_fill_inst (
		.clk        (clk),
		.rst        (rst),
		.bus_rsp    (bus_rsp),
		.vtags      (vtags),
		.fetch_adr  (fetch_adr),
		.snoop_v    (snoop_v),
		.snoop_adr  (snoop_adr),
		.snoop_cid  (snoop_cid),
		.hit        (fetch_hit),
		.fetch_data (fetch_data)
	);

endmodule

// File: test/bus_memory_model.sv
/*
 * Behavioral bus slave for the fetch bus
 * Random retry, a queue of accepted beats and out-of-order acks
 * whose data is built from the beat address
 */
module bus_memory_model (
	input  logic                     clk,
	input  logic                     rst,
	input  fetch_bus_pkg::bus_req_t  bus_req,
	output fetch_bus_pkg::bus_rsp_t  bus_rsp
);
	import fetch_bus_pkg::*;

	typedef struct packed {
		tid_t     tid;
		address_t adr;
	} beat_t;

	beat_t pending [$];
	logic  drain;

	initial begin
		bus_rsp = '0;
		drain = 1'b0;
	end

	// One process samples on the rising edge and drives on the falling edge
	always begin
		beat_t beat;
		int    pick;
		@(posedge clk);
		if (rst) begin
			pending.delete();
			drain = 1'b0;
		end else if (bus_req.stb && !bus_rsp.rty) begin
			beat.tid = bus_req.tid;
			beat.adr = bus_req.vadr;
			pending.push_back(beat);
			// Once the last beat is in, the whole burst is returned quickly
			if (bus_req.cti == EOB)
				drain = 1'b1;
		end
		@(negedge clk);
		bus_rsp.ack = 1'b0;
		bus_rsp.rty = ($urandom % 3 == 0) && !rst;
		// Before the burst ends only a few acks trickle out
		if (!rst && pending.size() > 0 && (drain || $urandom % 4 == 0)) begin
			pick = $urandom % pending.size();
			beat = pending[pick];
			pending.delete(pick);
			bus_rsp.ack = 1'b1;
			bus_rsp.tid = beat.tid;
			bus_rsp.dat = {beat.adr + 32'd3, beat.adr + 32'd2, beat.adr + 32'd1, beat.adr};
			if (pending.size() == 0)
				drain = 1'b0;
		end
	end

endmodule

// File: test/tb_icache_miss_unit.sv
/*
 * Testbench for the instruction cache miss unit
 * Clock, reset, fetch and snoop stimulus, bus monitor with checks,
 * memory model instance
 */
module tb_icache_miss_unit;
	import fetch_bus_pkg::*;
	import icache_pkg::*;

	localparam logic [5:0] CORE_NO = 6'd1;
	localparam logic [5:0] CHANNEL_ID = 6'd2;
	localparam int BACKOFF_WAIT = 6;
	localparam int STARTUP_CYCLES = 4 * CHANNEL_ID + 1;
	localparam int WAIT_LIMIT = 400;

	logic     clk = 1'b0;
	logic     rst;
	address_t fetch_adr;
	asid_t    fetch_asid;
	bus_rsp_t bus_rsp;
	logic     snoop_v;
	address_t snoop_adr;
	logic [5:0] snoop_cid;
	bus_req_t bus_req;
	logic     fetch_hit;
	data_t    fetch_data;

	// Monitor state
	bus_req_t   held;
	logic       held_rty;
	logic       hit_q;
	int         quiet_left;
	int         edges_after_reset;
	int         beat_idx;
	int         accepts;
	address_t   burst_base;
	logic [3:0] first_tranid;

	always #4 clk = ~clk;

	icache_miss_unit #(
		.CORE_NO      (CORE_NO),
		.CHANNEL_ID   (CHANNEL_ID),
		.BACKOFF_WAIT (BACKOFF_WAIT)
	) icache_miss_unit_inst (
		.clk        (clk),
		.rst        (rst),
		.fetch_adr  (fetch_adr),
		.fetch_asid (fetch_asid),
		.bus_rsp    (bus_rsp),
		.snoop_v    (snoop_v),
		.snoop_adr  (snoop_adr),
		.snoop_cid  (snoop_cid),
		.bus_req    (bus_req),
		.fetch_hit  (fetch_hit),
		.fetch_data (fetch_data)
	);

	bus_memory_model bus_memory_model_inst (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	task automatic stop_failed();
		$display("Simulation FAILED");
		$fatal(1, "stopping on the first error");
	endtask

	task automatic report_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		$display("[ERROR] time %0t %s is %0h, expected %0h", $time, name, got, exp);
		stop_failed();
	endtask

	task automatic report_text(input string msg);
		$display("Failure at time %0t, %s", $time, msg);
		stop_failed();
	endtask

	// Lane n of a beat holds the beat address plus n
	function automatic data_t beat_pattern(input address_t adr);
		data_t d;
		int    lane;
		for (lane = 0; lane < 4; lane++)
			d[lane*32 +: 32] = adr + lane;
		return d;
	endfunction

	// ======================================================================
	// Bus monitor sampling on the rising edge
	// ======================================================================
	always @(posedge clk) begin
		cti_t       exp_cti;
		logic [3:0] exp_tranid;
		if (rst) begin
			held = '0;
			held_rty = 1'b0;
			hit_q = 1'b0;
			quiet_left = 0;
			edges_after_reset = 0;
			beat_idx = 0;
			accepts = 0;
		end else begin
			if (edges_after_reset < STARTUP_CYCLES) begin
				assert (!bus_req.stb) else report_text("stb raised during the startup stagger");
			end
			// A retried beat must stay on the bus unchanged
			if (held.stb && held_rty) begin
				assert (bus_req.stb) else report_value("bus_req.stb", bus_req.stb, 1'b1);
				assert (bus_req.vadr == held.vadr)
					else report_value("bus_req.vadr", bus_req.vadr, held.vadr);
				assert (bus_req.tid == held.tid)
					else report_value("bus_req.tid", bus_req.tid, held.tid);
				assert (bus_req.cti == held.cti)
					else report_value("bus_req.cti", bus_req.cti, held.cti);
			end
			if (quiet_left > 0) begin
				assert (!bus_req.stb) else report_value("bus_req.stb", bus_req.stb, 1'b0);
				assert (!bus_req.cyc) else report_value("bus_req.cyc", bus_req.cyc, 1'b0);
				quiet_left--;
			end
			if (!fetch_hit && hit_q)
				accepts = 0;
			if (bus_req.stb && !bus_rsp.rty) begin
				if (beat_idx == 0) begin
					burst_base = fetch_adr & 32'hffff_ffc0;
					first_tranid = bus_req.tid.tranid;
				end
				exp_cti = (beat_idx == 3) ? EOB : FIXED;
				exp_tranid = 4'(first_tranid + beat_idx);
				assert (bus_req.cyc) else report_value("bus_req.cyc", bus_req.cyc, 1'b1);
				assert (!bus_req.we) else report_value("bus_req.we", bus_req.we, 1'b0);
				assert (bus_req.sel == 16'hffff)
					else report_value("bus_req.sel", bus_req.sel, 16'hffff);
				assert (bus_req.blen == 6'd4)
					else report_value("bus_req.blen", bus_req.blen, 6'd4);
				assert (bus_req.asid == fetch_asid)
					else report_value("bus_req.asid", bus_req.asid, fetch_asid);
				assert (bus_req.vadr == burst_base + 16 * beat_idx)
					else report_value("bus_req.vadr", bus_req.vadr, burst_base + 16 * beat_idx);
				assert (bus_req.cti == exp_cti)
					else report_value("bus_req.cti", bus_req.cti, exp_cti);
				assert (bus_req.tid.tranid == exp_tranid)
					else report_value("bus_req.tid.tranid", bus_req.tid.tranid, exp_tranid);
				assert (bus_req.tid.core == CORE_NO)
					else report_value("bus_req.tid.core", bus_req.tid.core, CORE_NO);
				assert (bus_req.tid.channel == CHANNEL_ID)
					else report_value("bus_req.tid.channel", bus_req.tid.channel, CHANNEL_ID);
				if (beat_idx == 3)
					quiet_left = BACKOFF_WAIT;
				beat_idx = (beat_idx + 1) % 4;
				accepts++;
			end
			// A foreign snoop on the fetch index forces a backoff as well
			if (snoop_v && snoop_cid != CHANNEL_ID &&
					snoop_adr[INDEX_HI_BIT:LINE_LO_BIT] == fetch_adr[INDEX_HI_BIT:LINE_LO_BIT])
				quiet_left = BACKOFF_WAIT;
			if (fetch_hit && !hit_q) begin
				assert (accepts == 4) else report_value("accepted beats per line", accepts, 4);
			end
			held = bus_req;
			held_rty = bus_rsp.rty;
			hit_q = fetch_hit;
			edges_after_reset++;
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================
	task automatic wait_hit(input logic level, input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (fetch_hit !== level && n < WAIT_LIMIT);
		if (fetch_hit !== level)
			report_text({"timed out waiting for ", what});
	endtask

	// Every quarter of a filled line must read back the model's pattern
	task automatic check_quarters(input address_t line);
		int q;
		for (q = 0; q < 4; q++) begin
			@(negedge clk);
			fetch_adr = line + 16 * q;
			@(posedge clk);
			assert (fetch_hit) else report_value("fetch_hit", fetch_hit, 1'b1);
			assert (fetch_data == beat_pattern(line + 16 * q))
				else report_value("fetch_data", fetch_data, beat_pattern(line + 16 * q));
		end
	endtask

	task automatic fill_and_check(input address_t line);
		@(negedge clk);
		fetch_adr = line;
		wait_hit(1'b1, "the line fill");
		check_quarters(line);
	endtask

	task automatic send_snoop(input address_t adr, input logic [5:0] cid);
		@(negedge clk);
		snoop_v = 1'b1;
		snoop_adr = adr;
		snoop_cid = cid;
		@(negedge clk);
		snoop_v = 1'b0;
	endtask

	// Hit must survive two edges after a snoop that does not concern the line
	task automatic expect_hit_kept();
		repeat (2) begin
			@(posedge clk);
			assert (fetch_hit) else report_value("fetch_hit", fetch_hit, 1'b1);
		end
	endtask

	initial begin
		address_t line;
		int       i;
		void'($urandom(97));
		rst = 1'b1;
		fetch_adr = 32'h0000_1240;
		fetch_asid = 8'h3c;
		snoop_v = 1'b0;
		snoop_adr = '0;
		snoop_cid = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		assert (!bus_req.cyc) else report_value("bus_req.cyc", bus_req.cyc, 1'b0);
		assert (!bus_req.stb) else report_value("bus_req.stb", bus_req.stb, 1'b0);
		assert (bus_req.cti == CLASSIC) else report_value("bus_req.cti", bus_req.cti, CLASSIC);
		assert (!fetch_hit) else report_value("fetch_hit", fetch_hit, 1'b0);

		fill_and_check(32'h0000_1240);
		fill_and_check(32'h0000_3380);
		// Same set as the first line with another tag
		fill_and_check(32'h0000_5a40);
		for (i = 0; i < 4; i++) begin
			line = $urandom & 32'hffff_ffc0;
			fill_and_check(line);
		end

		// Snoops against a line in set 3
		fill_and_check(32'h0000_26c0);
		send_snoop(32'h0000_99c0, CHANNEL_ID);
		expect_hit_kept();
		send_snoop(32'h0000_9980, 6'd5);
		expect_hit_kept();
		send_snoop(32'h0000_99c0, 6'd5);
		@(posedge clk);
		assert (!fetch_hit) else report_value("fetch_hit", fetch_hit, 1'b0);
		wait_hit(1'b1, "the refill after a snoop");
		check_quarters(32'h0000_26c0);

		@(negedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: sim.f
design/fetch_bus_pkg.sv
design/icache_pkg.sv
design/lfsr17.sv
design/icache_req_generator.sv
design/icache_line_fill.sv
design/icache_miss_unit.sv
test/bus_memory_model.sv
test/tb_icache_miss_unit.sv

// File: Bender.yml
package:
  name: icache_miss_unit

sources:
  - files:
      - design/fetch_bus_pkg.sv
      - design/icache_pkg.sv
      - design/lfsr17.sv
      - design/icache_req_generator.sv
      - design/icache_line_fill.sv
      - design/icache_miss_unit.sv
  - target: test
    files:
      - test/bus_memory_model.sv
      - test/tb_icache_miss_unit.sv
